/* src/rmt_pkg.sv */
// shared sizes, sub-action field layout and opcodes for the action engine RTL and testbench
package rmt_pkg;

    // PHV geometry
    localparam int NUM_CONT = 8;
    localparam int CONT_W   = 32;
    localparam int PHV_W    = NUM_CONT * CONT_W;

    // sub-action layout, from the top: opcode, src1, src2, immediate
    localparam int IDX_W    = 3;
    localparam int IMM_W    = 16;
    localparam int OP_W     = 4;
    localparam int ACT_W    = OP_W + 2 * IDX_W + IMM_W;
    localparam int ACTV_W   = NUM_CONT * ACT_W;
    localparam int SRC2_LSB = IMM_W;
    localparam int SRC1_LSB = SRC2_LSB + IDX_W;
    localparam int OP_LSB   = SRC1_LSB + IDX_W;

    // state table of the stateful lane
    localparam int STATE_DEPTH   = 16;
    localparam int STATE_AW      = 4;
    localparam int STATEFUL_LANE = 7;

    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_ADDI  = 4'd3,
        OP_SET   = 4'd4,
        OP_LOAD  = 4'd5,
        OP_STORE = 4'd6,
        OP_INCR  = 4'd7
    } alu_op_e;

    // opcode field of one sub-action
    function automatic alu_op_e act_op(input logic [ACT_W-1:0] sub_act);
        return alu_op_e'(sub_act[OP_LSB +: OP_W]);
    endfunction

    // stateless container rule, undefined and stateful codes keep the container
    function automatic logic [CONT_W-1:0] stateless_result(
        input alu_op_e           op,
        input logic [CONT_W-1:0] src1,
        input logic [CONT_W-1:0] src2,
        input logic [CONT_W-1:0] orig,
        input logic [IMM_W-1:0]  imm
    );
        logic [CONT_W-1:0] res;
        case (op)
            OP_ADD:  res = src1 + src2;
            OP_SUB:  res = src1 - src2;
            OP_ADDI: res = src1 + {{(CONT_W-IMM_W){1'b0}}, imm};
            OP_SET:  res = {{(CONT_W-IMM_W){1'b0}}, imm};
            default: res = orig;
        endcase
        return res;
    endfunction

endpackage

/* src/alu_issue_if.sv */
// registered operands and sub-actions handed from the PHV crossbar to the container ALUs
interface alu_issue_if;

    // qualifies the rest for exactly one cycle, no handshake
    logic issue_valid;

    // one slot per container, container 0 lowest
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::ACT_W-1:0]  sub_act;
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] op1;
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] op2;

    // untouched container value, used by NOP and STORE
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] orig;

    modport crossbar_mp (
        output issue_valid,
        output sub_act,
        output op1,
        output op2,
        output orig
    );

    modport alu_mp (
        input issue_valid,
        input sub_act,
        input op1,
        input op2,
        input orig
    );

endinterface

/* src/phv_crossbar.sv */
// operand crossbar: picks src1/src2 containers per lane and registers them for the ALU stage
module phv_crossbar (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [rmt_pkg::PHV_W-1:0]    phv_i,
    input  logic                         phv_valid_i,
    input  logic [rmt_pkg::ACTV_W-1:0]   action_i,
    alu_issue_if.crossbar_mp             issue
);

    // PHV and action vector split into slots
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] cont;
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::ACT_W-1:0]  act;

    // container indices per lane
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::IDX_W-1:0]  idx1;
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::IDX_W-1:0]  idx2;

    // selected operands before the register
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] sel1;
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] sel2;

    assign cont = phv_i;
    assign act  = action_i;

    always_comb begin
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            idx1[i] = act[i][rmt_pkg::SRC1_LSB +: rmt_pkg::IDX_W];
            idx2[i] = act[i][rmt_pkg::SRC2_LSB +: rmt_pkg::IDX_W];
        end
    end

    // full 8:1 mux per operand, every lane may read any container
    always_comb begin
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            sel1[i] = cont[idx1[i]];
            sel2[i] = cont[idx2[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.issue_valid <= 1'b0;
        end else begin
            issue.issue_valid <= phv_valid_i;
        end
    end

    // data only moves with a packet
    always_ff @(posedge clk) begin
        if (phv_valid_i) begin
            issue.sub_act <= act;
            issue.op1     <= sel1;
            issue.op2     <= sel2;
            issue.orig    <= cont;
        end
    end

endmodule

/* src/container_alu.sv */
// stateless ALU for one 32-bit container lane, result registered in the ALU stage
module container_alu #(
    parameter int LANE = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    alu_issue_if.alu_mp                 issue,
    output logic [rmt_pkg::CONT_W-1:0]  result_o
);

    // this lane's slot of the issue bundle
    logic [rmt_pkg::ACT_W-1:0]  sub_act;
    logic [rmt_pkg::CONT_W-1:0] src1;
    logic [rmt_pkg::CONT_W-1:0] src2;
    logic [rmt_pkg::CONT_W-1:0] orig;
    logic [rmt_pkg::IMM_W-1:0]  imm;
    rmt_pkg::alu_op_e           op;
    logic [rmt_pkg::CONT_W-1:0] result_d;

    assign sub_act = issue.sub_act[LANE];
    assign src1    = issue.op1[LANE];
    assign src2    = issue.op2[LANE];
    assign orig    = issue.orig[LANE];
    assign imm     = sub_act[rmt_pkg::IMM_W-1:0];

    // LOAD/STORE/INCR have no state here and fall back to NOP
    always_comb begin
        op       = rmt_pkg::act_op(sub_act);
        result_d = rmt_pkg::stateless_result(op, src1, src2, orig, imm);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_o <= '0;
        end else if (issue.issue_valid) begin
            result_o <= result_d;
        end
    end

endmodule

/* src/stateful_alu.sv */
// stateful container ALU: state table ops for the last lane plus Wishbone classic access
module stateful_alu (
    input  logic                          clk,
    input  logic                          rst_n,
    alu_issue_if.alu_mp                   issue,
    output logic [rmt_pkg::CONT_W-1:0]    result_o,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [rmt_pkg::STATE_AW-1:0]  wb_adr_i,
    input  logic [rmt_pkg::CONT_W-1:0]    wb_dat_i,
    output logic [rmt_pkg::CONT_W-1:0]    wb_dat_o,
    output logic                          wb_ack_o
);

    // per-flow counters and registers
    logic [rmt_pkg::CONT_W-1:0] state_tbl [rmt_pkg::STATE_DEPTH];

    logic [rmt_pkg::ACT_W-1:0]    sub_act;
    rmt_pkg::alu_op_e             op;
    logic [rmt_pkg::STATE_AW-1:0] st_addr;
    logic [rmt_pkg::CONT_W-1:0]   st_rd;
    logic [rmt_pkg::CONT_W-1:0]   st_incr;
    logic [rmt_pkg::CONT_W-1:0]   result_d;
    logic                         st_op;
    logic                         pkt_busy;
    logic                         wb_serve;

    // table write port, shared by packets and control plane
    logic                         tbl_we;
    logic [rmt_pkg::STATE_AW-1:0] tbl_addr;
    logic [rmt_pkg::CONT_W-1:0]   tbl_wdata;

    assign sub_act = issue.sub_act[rmt_pkg::STATEFUL_LANE];
    assign st_addr = sub_act[rmt_pkg::STATE_AW-1:0];
    assign st_rd   = state_tbl[st_addr];
    assign st_incr = st_rd + 1'b1;

    always_comb begin
        op       = rmt_pkg::act_op(sub_act);
        st_op    = 1'b0;
        result_d = rmt_pkg::stateless_result(op,
                                             issue.op1[rmt_pkg::STATEFUL_LANE],
                                             issue.op2[rmt_pkg::STATEFUL_LANE],
                                             issue.orig[rmt_pkg::STATEFUL_LANE],
                                             sub_act[rmt_pkg::IMM_W-1:0]);
        case (op)
            rmt_pkg::OP_LOAD: begin
                st_op    = 1'b1;
                result_d = st_rd;
            end
            // container keeps orig, already chosen by the stateless rule
            rmt_pkg::OP_STORE: st_op = 1'b1;
            rmt_pkg::OP_INCR: begin
                st_op    = 1'b1;
                result_d = st_incr;
            end
            default: ;
        endcase
    end

    // packets win, a held request waits for a free cycle
    assign pkt_busy = issue.issue_valid & st_op;
    assign wb_serve = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~pkt_busy;

    always_comb begin
        tbl_we    = 1'b0;
        tbl_addr  = st_addr;
        tbl_wdata = issue.op1[rmt_pkg::STATEFUL_LANE];
        if (pkt_busy && op == rmt_pkg::OP_STORE) begin
            tbl_we = 1'b1;
        end else if (pkt_busy && op == rmt_pkg::OP_INCR) begin
            tbl_we    = 1'b1;
            tbl_wdata = st_incr;
        end else if (wb_serve && wb_we_i) begin
            tbl_we    = 1'b1;
            tbl_addr  = wb_adr_i;
            tbl_wdata = wb_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rmt_pkg::STATE_DEPTH; i++) begin
                state_tbl[i] <= '0;
            end
        end else if (tbl_we) begin
            state_tbl[tbl_addr] <= tbl_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_o <= '0;
            wb_ack_o <= 1'b0;
        end else begin
            if (issue.issue_valid) begin
                result_o <= result_d;
            end
            // one-cycle ack after the serving cycle
            wb_ack_o <= wb_serve;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (wb_serve && !wb_we_i) begin
            wb_dat_o <= state_tbl[wb_adr_i];
        end
    end

endmodule

/* src/action_engine.sv */
// action engine top: crossbar, eight container ALUs and the output PHV register
module action_engine (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rmt_pkg::PHV_W-1:0]     phv_i,
    input  logic                          phv_valid_i,
    input  logic [rmt_pkg::ACTV_W-1:0]    action_i,
    output logic [rmt_pkg::PHV_W-1:0]     phv_o,
    output logic                          phv_valid_o,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [rmt_pkg::STATE_AW-1:0]  wb_adr_i,
    input  logic [rmt_pkg::CONT_W-1:0]    wb_dat_i,
    output logic [rmt_pkg::CONT_W-1:0]    wb_dat_o,
    output logic                          wb_ack_o
);

    alu_issue_if issue ();

    // ALU outputs, container 0 lowest
    logic [rmt_pkg::NUM_CONT-1:0][rmt_pkg::CONT_W-1:0] result;

    // valid of the ALU stage
    logic alu_valid_q;

    phv_crossbar crossbar_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phv_i       (phv_i),
        .phv_valid_i (phv_valid_i),
        .action_i    (action_i),
        .issue       (issue)
    );

    // stateless lanes below the stateful one
    generate
        for (genvar g = 0; g < rmt_pkg::STATEFUL_LANE; g++) begin : g_alu
            container_alu #(
                .LANE (g)
            ) alu_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .issue    (issue),
                .result_o (result[g])
            );
        end
    endgenerate

    stateful_alu stateful_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .result_o (result[rmt_pkg::STATEFUL_LANE]),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid_q <= 1'b0;
            phv_valid_o <= 1'b0;
            phv_o       <= '0;
        end else begin
            alu_valid_q <= issue.issue_valid;
            phv_valid_o <= alu_valid_q;
            // holds between packets
            if (alu_valid_q) begin
                phv_o <= result;
            end
        end
    end

endmodule

/* sim/tb_action_engine.sv */
// self-checking testbench for action_engine: random packets against a state model, Wishbone access
module tb_action_engine;

    localparam int CLK_HALF   = 20;
    localparam int DRV_DLY    = 5;
    localparam int MAX_CYCLES = 5000;

    logic                             clk;
    logic                             rst_n;
    logic [rmt_pkg::PHV_W-1:0]        phv_i;
    logic                             phv_valid_i;
    logic [rmt_pkg::ACTV_W-1:0]       action_i;
    logic [rmt_pkg::PHV_W-1:0]        phv_o;
    logic                             phv_valid_o;
    logic                             wb_cyc_i;
    logic                             wb_stb_i;
    logic                             wb_we_i;
    logic [rmt_pkg::STATE_AW-1:0]     wb_adr_i;
    logic [rmt_pkg::CONT_W-1:0]       wb_dat_i;
    logic [rmt_pkg::CONT_W-1:0]       wb_dat_o;
    logic                             wb_ack_o;

    // model of the state table and expected outputs in packet order
    logic [31:0]                      rng_state = 32'd61;
    logic [rmt_pkg::CONT_W-1:0]       model_state [rmt_pkg::STATE_DEPTH];
    logic [rmt_pkg::PHV_W-1:0]        exp_q [$];
    logic [rmt_pkg::PHV_W-1:0]        exp_phv;

    // cycle at which each packet is due at the output
    int                               exp_cyc_q [$];
    int                               exp_cyc;

    // phv_o holds the last output between packets, zero after reset
    logic [rmt_pkg::PHV_W-1:0]        last_phv = '0;

    int in_cnt       = 0;
    int out_cnt      = 0;
    int req_cnt      = 0;
    int ack_cnt      = 0;
    int phv_errs     = 0;
    int wb_errs      = 0;
    int proto_errs   = 0;
    int seq_errs     = 0;
    int timeout_errs = 0;
    int cycle_cnt    = 0;

    action_engine action_engine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .phv_i       (phv_i),
        .phv_valid_i (phv_valid_i),
        .action_i    (action_i),
        .phv_o       (phv_o),
        .phv_valid_o (phv_valid_o),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // xorshift32, one step per call
    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [rmt_pkg::PHV_W-1:0] rand_phv();
        logic [rmt_pkg::PHV_W-1:0] phv;
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            phv[i*rmt_pkg::CONT_W +: rmt_pkg::CONT_W] = rand32();
        end
        return phv;
    endfunction

    // any code on lanes 0-6, lane 7 kept off the stateful codes
    function automatic logic [rmt_pkg::ACTV_W-1:0] rand_action();
        logic [rmt_pkg::ACTV_W-1:0] act;
        logic [31:0]                r;
        logic [3:0]                 op;
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            r  = rand32();
            op = r[29:26];
            if (i == rmt_pkg::STATEFUL_LANE && op >= 4'd5 && op <= 4'd7) begin
                op = {2'b00, r[31:30]};
            end
            act[i*rmt_pkg::ACT_W +: rmt_pkg::ACT_W] = {op, r[21:0]};
        end
        return act;
    endfunction

    // overwrite the lane 7 slot with a state op on one entry
    function automatic logic [rmt_pkg::ACTV_W-1:0] with_state_op(
        input logic [rmt_pkg::ACTV_W-1:0] act,
        input logic [3:0]                 op,
        input logic [3:0]                 addr
    );
        logic [rmt_pkg::ACTV_W-1:0] res;
        logic [31:0]                r;
        res = act;
        r   = rand32();
        res[rmt_pkg::STATEFUL_LANE*rmt_pkg::ACT_W +: rmt_pkg::ACT_W] = {op, r[21:4], addr};
        return res;
    endfunction

    // per-container rule, arithmetic wraps at 32 bits
    function automatic logic [31:0] lane_rule(
        input logic [3:0]  op,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [31:0] orig,
        input logic [15:0] imm
    );
        case (op)
            4'd1:    return a + b;
            4'd2:    return a - b;
            4'd3:    return a + {16'h0000, imm};
            4'd4:    return {16'h0000, imm};
            default: return orig;
        endcase
    endfunction

    // expected PHV of one packet, state table updated in packet order
    function automatic void predict(
        input logic [rmt_pkg::PHV_W-1:0]  phv,
        input logic [rmt_pkg::ACTV_W-1:0] act
    );
        logic [rmt_pkg::PHV_W-1:0] exp;
        logic [25:0]               sa;
        logic [3:0]                op;
        logic [2:0]                s1;
        logic [2:0]                s2;
        logic [31:0]               res;
        for (int i = 0; i < rmt_pkg::NUM_CONT; i++) begin
            sa  = act[i*rmt_pkg::ACT_W +: rmt_pkg::ACT_W];
            op  = sa[25:22];
            s1  = sa[21:19];
            s2  = sa[18:16];
            res = lane_rule(op, phv[s1*32 +: 32], phv[s2*32 +: 32], phv[i*32 +: 32], sa[15:0]);
            if (i == rmt_pkg::STATEFUL_LANE) begin
                case (op)
                    4'd5: res = model_state[sa[3:0]];
                    4'd6: model_state[sa[3:0]] = phv[s1*32 +: 32];
                    4'd7: begin
                        model_state[sa[3:0]] = model_state[sa[3:0]] + 32'd1;
                        res = model_state[sa[3:0]];
                    end
                    default: ;
                endcase
            end
            exp[i*32 +: 32] = res;
        end
        exp_q.push_back(exp);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic send_packet(
        input logic [rmt_pkg::PHV_W-1:0]  phv,
        input logic [rmt_pkg::ACTV_W-1:0] act
    );
        next_cycle();
        phv_i       = phv;
        action_i    = act;
        phv_valid_i = 1'b1;
        predict(phv, act);
        // output due three clock edges later
        exp_cyc_q.push_back(cycle_cnt + 3);
        in_cnt++;
    endtask

    task automatic idle_cycle();
        next_cycle();
        phv_valid_i = 1'b0;
    endtask

    // wait until every packet has left the pipeline
    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // one classic cycle, request held until ack
    task automatic wb_access(
        input  logic        we,
        input  logic [3:0]  adr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata
    );
        next_cycle();
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        req_cnt++;
        @(negedge clk);
        while (!wb_ack_o) @(negedge clk);
        rdata = wb_dat_o;
        next_cycle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic finish_run();
        int total;
        total = phv_errs + wb_errs + proto_errs + seq_errs + timeout_errs;
        $display("Errors: phv_o %0d, wb_dat_o %0d, protocol %0d, sequence %0d, timeout %0d",
                 phv_errs, wb_errs, proto_errs, seq_errs, timeout_errs);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && phv_valid_o) begin
            assert (exp_q.size() != 0) else begin
                proto_errs++;
                $display("Error: output PHV appeared with no packet outstanding");
            end
            if (exp_q.size() != 0) begin
                exp_phv = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                out_cnt++;
                assert (phv_o === exp_phv) else begin
                    phv_errs++;
                    $display("Mismatch phv_o: got 0x%h expected 0x%h", phv_o, exp_phv);
                end
                assert (cycle_cnt == exp_cyc) else begin
                    seq_errs++;
                    $display("Error: output PHV came out in cycle %0d instead of cycle %0d",
                             cycle_cnt, exp_cyc);
                end
                last_phv = exp_phv;
            end
        end else if (rst_n) begin
            assert (phv_o === last_phv) else begin
                phv_errs++;
                $display("Mismatch phv_o while idle: got 0x%h expected 0x%h", phv_o, last_phv);
            end
        end
        if (rst_n && wb_ack_o) begin
            ack_cnt++;
            assert (wb_cyc_i && wb_stb_i) else begin
                proto_errs++;
                $display("Error: wb_ack_o raised with no request held");
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        timeout_errs++;
        $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
        finish_run();
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [3:0]  addr;
        logic [3:0]  op;
        rst_n       = 1'b0;
        phv_i       = '0;
        phv_valid_i = 1'b0;
        action_i    = '0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        for (int e = 0; e < rmt_pkg::STATE_DEPTH; e++) begin
            model_state[e] = '0;
        end
        repeat (4) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        // quiet outputs after reset
        repeat (8) begin
            @(negedge clk);
            assert (!phv_valid_o && !wb_ack_o) else begin
                seq_errs++;
                $display("Error: phv_valid_o or wb_ack_o went high before any traffic");
            end
        end

        // stateless traffic with random single-cycle gaps
        for (int n = 0; n < 300; n++) begin
            r = rand32();
            if (r[1:0] == 2'd0) begin
                idle_cycle();
            end
            send_packet(rand_phv(), rand_action());
        end
        drain();

        // state ops on lane 7, half of them reuse the previous entry
        addr = 4'd0;
        for (int n = 0; n < 200; n++) begin
            r = rand32();
            if (!r[8]) begin
                addr = r[12:9];
            end
            op = (r[5:4] == 2'd1) ? rmt_pkg::OP_STORE :
                 (r[5:4] == 2'd2) ? rmt_pkg::OP_INCR : rmt_pkg::OP_LOAD;
            if (r[2:0] == 3'd0) begin
                idle_cycle();
            end
            send_packet(rand_phv(), with_state_op(rand_action(), op, addr));
        end
        drain();

        // control plane fills the table, packets read it back
        for (int e = 0; e < rmt_pkg::STATE_DEPTH; e++) begin
            wdata = rand32();
            wb_access(1'b1, 4'(e), wdata, rdata);
            model_state[e] = wdata;
        end
        for (int e = 0; e < rmt_pkg::STATE_DEPTH; e++) begin
            send_packet(rand_phv(), with_state_op(rand_action(), rmt_pkg::OP_LOAD, 4'(e)));
        end
        drain();

        // packets update the table, control plane reads it
        for (int n = 0; n < 64; n++) begin
            r    = rand32();
            addr = r[3:0];
            op   = r[4] ? rmt_pkg::OP_INCR : rmt_pkg::OP_STORE;
            send_packet(rand_phv(), with_state_op(rand_action(), op, addr));
        end
        drain();
        for (int e = 0; e < rmt_pkg::STATE_DEPTH; e++) begin
            wb_access(1'b0, 4'(e), 32'd0, rdata);
            assert (rdata === model_state[e]) else begin
                wb_errs++;
                $display("Mismatch wb_dat_o entry %0d: got 0x%h expected 0x%h",
                         e, rdata, model_state[e]);
            end
        end

        repeat (4) idle_cycle();
        assert (out_cnt == in_cnt && exp_q.size() == 0) else begin
            seq_errs++;
            $display("Error: %0d packets sent but %0d came out", in_cnt, out_cnt);
        end
        assert (ack_cnt == req_cnt) else begin
            seq_errs++;
            $display("Error: %0d Wishbone requests got %0d acks", req_cnt, ack_cnt);
        end
        finish_run();
    end

endmodule

/* verilog.f */
src/rmt_pkg.sv
src/alu_issue_if.sv
src/phv_crossbar.sv
src/container_alu.sv
src/stateful_alu.sv
src/action_engine.sv
sim/tb_action_engine.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         := tb_action_engine
RTL_TOP     := action_engine
FILELIST    := verilog.f
BUILD_DIR   := obj_dir
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
